/* Bender.yml */
package:
  name: conv_accel

export_include_dirs:
  - src

sources:
  - src/conv_pkg.sv
  - src/conv_ctrl.sv
  - src/conv_mac.sv
  - src/feat_accum.sv
  - src/out_port.sv
  - src/conv_top.sv
  - target: test
    files:
      - dv/conv_assert.sv
      - dv/conv_tb.sv

/* dv/conv_assert.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_defs.svh"

module conv_assert (
  input wire                    clk,
  input wire                    xrst,
  input wire                    out_req,
  input wire                    out_ack,
  input wire [`CONV_OWIDTH-1:0] out_data,
  input wire                    out_last
);

  int fail_count = 0;

  // ==============================
  // four-phase output port
  // ==============================

  // request holds until acknowledged
  req_held: assert property (@(posedge clk) disable iff (!xrst)
    out_req && !out_ack |=> out_req)
    else begin
      fail_count++;
      $error("out_req dropped before out_ack rose");
    end

  data_stable: assert property (@(posedge clk) disable iff (!xrst)
    out_req && $past(out_req) |-> $stable(out_data) && $stable(out_last))
    else begin
      fail_count++;
      $error("out_data or out_last changed during a request");
    end

  // old ack still high, no new request yet
  no_early_req: assert property (@(posedge clk) disable iff (!xrst)
    !out_req && out_ack |=> !out_req)
    else begin
      fail_count++;
      $error("out_req rose before out_ack fell");
    end

  reset_quiet: assert property (@(posedge clk)
    !xrst |=> !out_req)
    else begin
      fail_count++;
      $error("out_req high during reset");
    end

endmodule

bind conv_top conv_assert conv_assert_i (
  .clk     (clk),
  .xrst    (xrst),
  .out_req (out_req),
  .out_ack (out_ack),
  .out_data(out_data),
  .out_last(out_last)
);

`default_nettype wire

/* dv/conv_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_defs.svh"

module conv_tb;

  localparam int WAIT_LIMIT = 4000;
  localparam int IDLE_LIMIT = 200;

  logic                           clk;
  logic                           xrst;
  conv_pkg::core_phase_e          core_phase;
  conv_pkg::ctrl_bus_t            in_ctrl;
  logic signed [`CONV_PWIDTH-1:0] in_pixel;
  logic signed [`CONV_PWIDTH-1:0] weight;
  logic [`CONV_LWIDTH-1:0]        fea_height;
  logic [`CONV_LWIDTH-1:0]        fea_width;
  logic                           first_input;
  logic                           last_input;
  logic                           out_ack = 1'b0;
  logic                           out_req;
  logic signed [`CONV_OWIDTH-1:0] out_data;
  logic                           out_last;

  // reference feature memory, one int per address
  int                       model [1 << `CONV_FACCUM];
  logic [`CONV_OWIDTH-1:0]  exp_data [$];
  logic                     exp_last [$];
  int rx_count;
  int check_count;
  int error_count;
  int test_count;
  int ack_max;
  int ack_wait;
  int ack_state;

  conv_top conv_top_i (
    .clk        (clk),
    .xrst       (xrst),
    .core_phase (core_phase),
    .in_ctrl    (in_ctrl),
    .in_pixel   (in_pixel),
    .weight     (weight),
    .fea_height (fea_height),
    .fea_width  (fea_width),
    .first_input(first_input),
    .last_input (last_input),
    .out_ack    (out_ack),
    .out_req    (out_req),
    .out_data   (out_data),
    .out_last   (out_last)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==============================
  // reference model helpers
  // ==============================

  function automatic conv_pkg::ctrl_bus_t frame(input logic s, input logic v, input logic p);
    conv_pkg::ctrl_bus_t c;
    c.start = s;
    c.valid = v;
    c.stop  = p;
    return c;
  endfunction

  // clamp to the signed 16-bit range
  function automatic logic [`CONV_OWIDTH-1:0] saturate(input int v);
    if (v > 32767) return 16'h7fff;
    if (v < -32768) return 16'h8000;
    return v[`CONV_OWIDTH-1:0];
  endfunction

  // large mode alternates sign by address so both clamps show up
  function automatic int pick_pixel(input bit big, input int addr);
    int mag;
    if (!big) return int'($urandom % 256) - 128;
    mag = 100 + int'($urandom % 28);
    return (addr % 2) ? -mag : mag;
  endfunction

  function automatic int pick_weight(input bit big);
    if (!big) return int'($urandom % 256) - 128;
    return 100 + int'($urandom % 28);
  endfunction

  function automatic int errors_so_far();
    return error_count + conv_top_i.conv_assert_i.fail_count;
  endfunction

  // ==============================
  // ack responder and word check
  // ==============================

  task automatic check_word(input logic [`CONV_OWIDTH-1:0] data, input logic last);
    logic [`CONV_OWIDTH-1:0] want_data;
    logic                    want_last;
    rx_count++;
    if (exp_data.size() == 0) begin
      $display("output word %0d arrived with no word expected", rx_count);
      error_count++;
    end else begin
      want_data = exp_data.pop_front();
      want_last = exp_last.pop_front();
      check_count += 2;
      assert (data === want_data) else begin
        $display("[ERROR] out_data expected 0x%h actual 0x%h at word %0d",
                 want_data, data, rx_count);
        error_count++;
      end
      assert (last === want_last) else begin
        $display("[ERROR] out_last expected 0x%h actual 0x%h at word %0d",
                 want_last, last, rx_count);
        error_count++;
      end
    end
  endtask

  // random delay before raising and before releasing ack
  always @(posedge clk) begin
    if (!xrst) begin
      out_ack   <= 1'b0;
      ack_state <= 0;
      ack_wait  <= 0;
    end else begin
      case (ack_state)
        0: if (out_req) begin
          ack_wait  <= int'($urandom % (ack_max + 1));
          ack_state <= 1;
        end
        1: if (ack_wait == 0) begin
          out_ack <= 1'b1;
          check_word(out_data, out_last);
          ack_state <= 2;
        end else begin
          ack_wait <= ack_wait - 1;
        end
        2: if (!out_req) begin
          ack_wait  <= int'($urandom % (ack_max + 1));
          ack_state <= 3;
        end
        3: if (ack_wait == 0) begin
          out_ack   <= 1'b0;
          ack_state <= 0;
        end else begin
          ack_wait <= ack_wait - 1;
        end
        default: ack_state <= 0;
      endcase
    end
  end

  // ==============================
  // stimulus
  // ==============================

  task automatic send_channel(input int h, input int w, input int wt,
                              input bit first, input bit last, input bit big);
    int p;
    int i;
    @(posedge clk);
    in_ctrl     <= frame(1'b1, 1'b0, 1'b0);
    weight      <= wt[`CONV_PWIDTH-1:0];
    fea_height  <= h[`CONV_LWIDTH-1:0];
    fea_width   <= w[`CONV_LWIDTH-1:0];
    first_input <= first;
    last_input  <= last;
    for (i = 0; i < h * w; i++) begin
      p = pick_pixel(big, i);
      model[i] = first ? p * wt : model[i] + p * wt;
      @(posedge clk);
      in_ctrl  <= frame(1'b0, 1'b1, 1'b0);
      in_pixel <= p[`CONV_PWIDTH-1:0];
    end
    @(posedge clk);
    in_ctrl <= frame(1'b0, 1'b0, 1'b1);
    @(posedge clk);
    in_ctrl <= '0;
  endtask

  task automatic wait_words(input int target);
    int cycles;
    cycles = 0;
    while (rx_count < target && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (rx_count < target) begin
      $display("timed out with %0d of %0d output words received", rx_count, target);
      error_count++;
      exp_data.delete();
      exp_last.delete();
    end
  endtask

  task automatic wait_port_idle();
    int cycles;
    cycles = 0;
    while ((out_req || out_ack) && cycles < IDLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (out_req || out_ack) begin
      $display("timed out waiting for the output handshake to return to idle");
      error_count++;
    end
  endtask

  task automatic run_layer(input int h, input int w, input int nch, input bit big);
    int k;
    int wt;
    int target;
    @(posedge clk);
    core_phase <= conv_pkg::PHASE_INPUT;
    repeat (2) @(posedge clk);
    for (k = 0; k < nch; k++) begin
      wt = pick_weight(big);
      send_channel(h, w, wt, k == 0, k == nch - 1, big);
      repeat (2) @(posedge clk);
    end
    // last writes still in the pipeline
    repeat (`CONV_D_CONV + `CONV_D_ACCUM + 2) @(posedge clk);
    for (k = 0; k < h * w; k++) begin
      exp_data.push_back(saturate(model[k]));
      exp_last.push_back(k == h * w - 1);
    end
    target = rx_count + h * w;
    core_phase <= conv_pkg::PHASE_OUTPUT;
    wait_words(target);
    wait_port_idle();
    // port must stay quiet after the final word
    repeat (20) begin
      @(posedge clk);
      check_count++;
      assert (!out_req) else begin
        $display("out_req rose again after the final word of the layer");
        error_count++;
      end
    end
    core_phase <= conv_pkg::PHASE_WAIT;
  endtask

  task automatic end_test(input string name, input int err_start);
    test_count++;
    $display("test %0d %s: %0d errors", test_count, name, errors_so_far() - err_start);
  endtask

  // ==============================
  // test sequence
  // ==============================

  initial begin
    int err_start;
    void'($urandom(18));
    xrst        = 1'b0;
    core_phase  = conv_pkg::PHASE_WAIT;
    in_ctrl     = '0;
    in_pixel    = '0;
    weight      = '0;
    fea_height  = '0;
    fea_width   = '0;
    first_input = 1'b0;
    last_input  = 1'b0;
    ack_max     = 3;
    repeat (10) @(posedge clk);
    xrst <= 1'b1;
    repeat (2) @(posedge clk);

    err_start = errors_so_far();
    run_layer(4, 5, 1, 1'b0);
    end_test("single channel", err_start);

    err_start = errors_so_far();
    run_layer(6, 3, 3, 1'b0);
    end_test("multi-channel accumulation", err_start);

    err_start = errors_so_far();
    run_layer(3, 4, 4, 1'b1);
    end_test("saturation", err_start);

    err_start = errors_so_far();
    ack_max = 9;
    run_layer(5, 5, 2, 1'b0);
    ack_max = 3;
    end_test("slow ack", err_start);

    err_start = errors_so_far();
    run_layer(7, 5, 2, 1'b0);
    run_layer(3, 4, 1, 1'b0);
    end_test("frame end and second layer", err_start);

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, errors_so_far());
    if (errors_so_far() == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
src/conv_pkg.sv
src/conv_ctrl.sv
src/conv_mac.sv
src/feat_accum.sv
src/out_port.sv
src/conv_top.sv
dv/conv_assert.sv
dv/conv_tb.sv

/* src/conv_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_defs.svh"

module conv_ctrl (
  input  wire                          clk,
  input  wire                          xrst,
  input  wire conv_pkg::core_phase_e   core_phase,
  input  wire conv_pkg::ctrl_bus_t     in_ctrl,
  input  wire [`CONV_LWIDTH-1:0]       fea_height,
  input  wire [`CONV_LWIDTH-1:0]       fea_width,
  input  wire                          first_input,
  input  wire                          last_input,
  input  wire                          ready,
  output conv_pkg::ctrl_bus_t          out_ctrl,
  output logic                         feat_we,
  output logic                         feat_rst,
  output logic [`CONV_FACCUM-1:0]      feat_waddr,
  output logic [`CONV_FACCUM-1:0]      feat_raddr
);

  localparam int D_CTRL = `CONV_D_CONV + `CONV_D_ACCUM;

  typedef enum logic {S_WAIT, S_ACTIVE} state_e;

  state_e                   state_r;
  conv_pkg::core_phase_e    phase_r;
  logic [`CONV_LWIDTH-1:0]  height_r;
  logic [`CONV_LWIDTH-1:0]  width_r;
  logic [`CONV_LWIDTH-1:0]  x_r;
  logic [`CONV_LWIDTH-1:0]  y_r;
  logic [`CONV_FACCUM-1:0]  addr_r;
  logic                     first_r;
  logic                     last_r;
  logic                     done_r;
  logic                     inflight_r;

  logic                     we_d   [`CONV_D_CONV];
  logic                     rst_d  [`CONV_D_CONV];
  logic [`CONV_FACCUM-1:0]  addr_d [`CONV_D_CONV];
  conv_pkg::ctrl_bus_t      ctrl_d [D_CTRL];

  logic in_beat;
  logic issue;
  logic at_end;

  // pixel accepted into the current channel
  assign in_beat = state_r == S_ACTIVE && phase_r == conv_pkg::PHASE_INPUT
                && in_ctrl.valid;

  // one output word at a time, none after the final coordinate
  assign issue = state_r == S_ACTIVE && phase_r == conv_pkg::PHASE_OUTPUT
              && ready && !inflight_r && !done_r;

  assign at_end = x_r == width_r - 1'b1 && y_r == height_r - 1'b1;

  // ==============================
  // state and frame parameters
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state_r <= S_WAIT;
    end else if (state_r == S_WAIT && in_ctrl.start) begin
      state_r <= S_ACTIVE;
    end else if (state_r == S_ACTIVE && out_ctrl.stop) begin
      state_r <= S_WAIT;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      phase_r <= conv_pkg::PHASE_WAIT;
    end else begin
      phase_r <= core_phase;
    end
  end

  // frame dimensions of the current layer
  always_ff @(posedge clk) begin
    if (in_ctrl.start) begin
      height_r <= fea_height;
      width_r  <= fea_width;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      first_r <= 1'b0;
      last_r  <= 1'b0;
    end else if (in_ctrl.start) begin
      first_r <= first_input;
      last_r  <= last_input;
    end
  end

  // ==============================
  // raster walk
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst || state_r == S_WAIT) begin
      x_r    <= '0;
      y_r    <= '0;
      addr_r <= '0;
    end else if (in_beat || issue) begin
      if (x_r == width_r - 1'b1) begin
        x_r <= '0;
        y_r <= (y_r == height_r - 1'b1) ? '0 : y_r + 1'b1;
      end else begin
        x_r <= x_r + 1'b1;
      end
      addr_r <= at_end ? '0 : addr_r + 1'b1;
    end
  end

  // cleared again by the next layer's first start
  always_ff @(posedge clk) begin
    if (!xrst || in_ctrl.start) begin
      done_r <= 1'b0;
    end else if (issue && at_end) begin
      done_r <= 1'b1;
    end
  end

  // covers the gap until out_port sees the word
  always_ff @(posedge clk) begin
    if (!xrst) begin
      inflight_r <= 1'b0;
    end else if (issue) begin
      inflight_r <= 1'b1;
    end else if (out_ctrl.valid) begin
      inflight_r <= 1'b0;
    end
  end

  // ==============================
  // feature memory control
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < `CONV_D_CONV; i++) begin
        we_d[i]  <= 1'b0;
        rst_d[i] <= 1'b0;
      end
    end else begin
      we_d[0]  <= in_beat;
      rst_d[0] <= in_beat && first_r;
      for (int i = 1; i < `CONV_D_CONV; i++) begin
        we_d[i]  <= we_d[i-1];
        rst_d[i] <= rst_d[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    addr_d[0] <= addr_r;
    for (int i = 1; i < `CONV_D_CONV; i++) begin
      addr_d[i] <= addr_d[i-1];
    end
  end

  // read one cycle ahead of the product, write address follows it
  assign feat_raddr = addr_d[`CONV_D_CONV-2];
  assign feat_waddr = addr_d[`CONV_D_CONV-1];
  assign feat_we    = we_d[`CONV_D_CONV-1];
  assign feat_rst   = rst_d[`CONV_D_CONV-1];

  // ==============================
  // output framing
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < D_CTRL; i++) begin
        ctrl_d[i] <= '0;
      end
    end else begin
      ctrl_d[0].start <= state_r == S_ACTIVE && in_ctrl.stop && last_r;
      ctrl_d[0].valid <= issue;
      ctrl_d[0].stop  <= issue && at_end;
      for (int i = 1; i < D_CTRL; i++) begin
        ctrl_d[i] <= ctrl_d[i-1];
      end
    end
  end

  assign out_ctrl = ctrl_d[D_CTRL-1];

endmodule

`default_nettype wire

/* src/conv_defs.svh */
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// ==============================
// datapath widths
// ==============================

// frame dimension and raster coordinate
`define CONV_LWIDTH 8

// signed pixel and weight
`define CONV_PWIDTH 8

// signed accumulator word, room for many channels
`define CONV_AWIDTH 24

// signed output word after saturation
`define CONV_OWIDTH 16

// feature memory address, covers 255x255
`define CONV_FACCUM 16

// ==============================
// pipeline depths
// ==============================

`define CONV_D_CONV  3
`define CONV_D_ACCUM 1

`endif

/* src/conv_mac.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_defs.svh"

module conv_mac (
  input  wire                             clk,
  input  wire                             xrst,
  input  wire                             start,
  input  wire signed [`CONV_PWIDTH-1:0]   in_pixel,
  input  wire signed [`CONV_PWIDTH-1:0]   weight,
  output logic signed [`CONV_AWIDTH-1:0]  product
);

  logic signed [`CONV_PWIDTH-1:0] weight_r;
  logic signed [`CONV_AWIDTH-1:0] prod_d [`CONV_D_CONV];

  // one weight per input channel
  always_ff @(posedge clk) begin
    if (!xrst) begin
      weight_r <= '0;
    end else if (start) begin
      weight_r <= weight;
    end
  end

  // ==============================
  // multiply pipeline
  // ==============================

  // operands sign extend to the accumulator width
  always_ff @(posedge clk) begin
    prod_d[0] <= in_pixel * weight_r;
    for (int i = 1; i < `CONV_D_CONV; i++) begin
      prod_d[i] <= prod_d[i-1];
    end
  end

  assign product = prod_d[`CONV_D_CONV-1];

endmodule

`default_nettype wire

/* src/conv_pkg.sv */
`default_nettype none

package conv_pkg;

  // ==============================
  // stream framing
  // ==============================

  // start precedes the first pixel, stop follows the last one
  typedef struct packed {
    logic start;
    logic valid;
    logic stop;
  } ctrl_bus_t;

  // ==============================
  // coarse layer phase
  // ==============================

  // driven from outside by the network sequencer
  typedef enum logic [1:0] {
    PHASE_WAIT    = 2'd0,
    PHASE_NETWORK = 2'd1,
    PHASE_INPUT   = 2'd2,
    PHASE_OUTPUT  = 2'd3
  } core_phase_e;

endpackage

`default_nettype wire

/* src/conv_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_defs.svh"

module conv_top (
  input  wire                             clk,
  input  wire                             xrst,
  input  wire conv_pkg::core_phase_e      core_phase,
  input  wire conv_pkg::ctrl_bus_t        in_ctrl,
  input  wire signed [`CONV_PWIDTH-1:0]   in_pixel,
  input  wire signed [`CONV_PWIDTH-1:0]   weight,
  input  wire [`CONV_LWIDTH-1:0]          fea_height,
  input  wire [`CONV_LWIDTH-1:0]          fea_width,
  input  wire                             first_input,
  input  wire                             last_input,
  input  wire                             out_ack,
  output logic                            out_req,
  output logic signed [`CONV_OWIDTH-1:0]  out_data,
  output logic                            out_last
);

  conv_pkg::ctrl_bus_t            out_ctrl;
  logic                           feat_we;
  logic                           feat_rst;
  logic [`CONV_FACCUM-1:0]        feat_waddr;
  logic [`CONV_FACCUM-1:0]        feat_raddr;
  logic signed [`CONV_AWIDTH-1:0] product;
  logic signed [`CONV_AWIDTH-1:0] feat_data;
  logic                           ready;

  // ==============================
  // control, multiply, accumulate, send
  // ==============================

  conv_ctrl conv_ctrl_i (
    .clk        (clk),
    .xrst       (xrst),
    .core_phase (core_phase),
    .in_ctrl    (in_ctrl),
    .fea_height (fea_height),
    .fea_width  (fea_width),
    .first_input(first_input),
    .last_input (last_input),
    .ready      (ready),
    .out_ctrl   (out_ctrl),
    .feat_we    (feat_we),
    .feat_rst   (feat_rst),
    .feat_waddr (feat_waddr),
    .feat_raddr (feat_raddr)
  );

  // weight is taken on the start beat
  conv_mac conv_mac_i (
    .clk     (clk),
    .xrst    (xrst),
    .start   (in_ctrl.start),
    .in_pixel(in_pixel),
    .weight  (weight),
    .product (product)
  );

  feat_accum feat_accum_i (
    .clk       (clk),
    .xrst      (xrst),
    .feat_we   (feat_we),
    .feat_rst  (feat_rst),
    .feat_waddr(feat_waddr),
    .feat_raddr(feat_raddr),
    .product   (product),
    .feat_data (feat_data)
  );

  out_port out_port_i (
    .clk      (clk),
    .xrst     (xrst),
    .out_ctrl (out_ctrl),
    .feat_data(feat_data),
    .out_ack  (out_ack),
    .ready    (ready),
    .out_req  (out_req),
    .out_data (out_data),
    .out_last (out_last)
  );

endmodule

`default_nettype wire

/* src/feat_accum.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_defs.svh"

module feat_accum (
  input  wire                             clk,
  input  wire                             xrst,
  input  wire                             feat_we,
  input  wire                             feat_rst,
  input  wire [`CONV_FACCUM-1:0]          feat_waddr,
  input  wire [`CONV_FACCUM-1:0]          feat_raddr,
  input  wire signed [`CONV_AWIDTH-1:0]   product,
  output logic signed [`CONV_AWIDTH-1:0]  feat_data
);

  localparam int DEPTH = 1 << `CONV_FACCUM;

  logic signed [`CONV_AWIDTH-1:0] mem [DEPTH];
  logic signed [`CONV_AWIDTH-1:0] rd_r;
  logic signed [`CONV_AWIDTH-1:0] add_d   [`CONV_D_ACCUM];
  logic [`CONV_FACCUM-1:0]        waddr_d [`CONV_D_ACCUM];
  logic                           we_d    [`CONV_D_ACCUM];

  // ==============================
  // memory
  // ==============================

  always_ff @(posedge clk) begin
    rd_r <= mem[feat_raddr];
    if (we_d[`CONV_D_ACCUM-1]) begin
      mem[waddr_d[`CONV_D_ACCUM-1]] <= add_d[`CONV_D_ACCUM-1];
    end
  end

  // ==============================
  // read-add stage
  // ==============================

  // first channel overwrites, output phase passes the read word through
  always_ff @(posedge clk) begin
    add_d[0]   <= feat_rst ? product : rd_r + (feat_we ? product : '0);
    waddr_d[0] <= feat_waddr;
    for (int i = 1; i < `CONV_D_ACCUM; i++) begin
      add_d[i]   <= add_d[i-1];
      waddr_d[i] <= waddr_d[i-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < `CONV_D_ACCUM; i++) begin
        we_d[i] <= 1'b0;
      end
    end else begin
      we_d[0] <= feat_we;
      for (int i = 1; i < `CONV_D_ACCUM; i++) begin
        we_d[i] <= we_d[i-1];
      end
    end
  end

  assign feat_data = add_d[`CONV_D_ACCUM-1];

endmodule

`default_nettype wire

/* src/out_port.sv */
`timescale 1ns/10ps
`default_nettype none
`include "conv_defs.svh"

module out_port (
  input  wire                             clk,
  input  wire                             xrst,
  input  wire conv_pkg::ctrl_bus_t        out_ctrl,
  input  wire signed [`CONV_AWIDTH-1:0]   feat_data,
  input  wire                             out_ack,
  output logic                            ready,
  output logic                            out_req,
  output logic signed [`CONV_OWIDTH-1:0]  out_data,
  output logic                            out_last
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_ACK_LOW} state_e;

  state_e                         state_r;
  logic signed [`CONV_OWIDTH-1:0] sat;
  logic signed [`CONV_OWIDTH-1:0] data_r;
  logic                           last_r;

  // in range when all bits above the output sign agree with it
  always_comb begin
    if (&feat_data[`CONV_AWIDTH-1:`CONV_OWIDTH-1]
        || ~|feat_data[`CONV_AWIDTH-1:`CONV_OWIDTH-1]) begin
      sat = feat_data[`CONV_OWIDTH-1:0];
    end else if (feat_data[`CONV_AWIDTH-1]) begin
      sat = {1'b1, {(`CONV_OWIDTH-1){1'b0}}};
    end else begin
      sat = {1'b0, {(`CONV_OWIDTH-1){1'b1}}};
    end
  end

  // ==============================
  // four-phase sender
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state_r <= S_IDLE;
    end else begin
      case (state_r)
        S_IDLE:    if (out_ctrl.valid) state_r <= S_REQ;
        S_REQ:     if (out_ack) state_r <= S_ACK_LOW;
        S_ACK_LOW: if (!out_ack) state_r <= S_IDLE;
        default:   state_r <= S_IDLE;
      endcase
    end
  end

  // held for the whole request
  always_ff @(posedge clk) begin
    if (state_r == S_IDLE && out_ctrl.valid) begin
      data_r <= sat;
      last_r <= out_ctrl.stop;
    end
  end

  assign ready    = state_r == S_IDLE && !out_ctrl.valid;
  assign out_req  = state_r == S_REQ;
  assign out_data = data_r;
  assign out_last = last_r;

endmodule

`default_nettype wire
